// File: id_stage.f
logic/decode_pkg.sv
logic/decode_ctrl_if.sv
logic/operand_fields_if.sv
logic/inst_classifier.sv
logic/operand_fetch.sv
logic/operand_select.sv
logic/id_stage.sv
tb/tb_clock.sv
tb/id_stage_checker.sv
tb/id_stage_tb.sv

// File: logic/decode_ctrl_if.sv
// decode control bus from the instruction classifier to the operand selector
`timescale 1ns/1ps

interface decode_ctrl_if;
    import decode_pkg::*;

    inst_class_t inst_class;
    alu_mode_t   alu_mode;
    opa_sel_t    opa_sel;
    opb_sel_t    opb_sel;
    logic        use_rs1;
    logic        use_rs2;
    logic        wen;

    modport cls (
        output inst_class, alu_mode, opa_sel, opb_sel,
        output use_rs1, use_rs2, wen
    );

    modport sel (
        input inst_class, alu_mode, opa_sel, opb_sel,
        input use_rs1, use_rs2, wen
    );

endinterface

// File: logic/decode_pkg.sv
// decode package with widths, vector types, decode enums and RISC-V opcode constants
package decode_pkg;

    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]     xlen_t;
    typedef logic [31:0]         inst_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [NUM_REGS-1:0] busy_t;     // one bit per gpr

    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_ALU_IMM,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE
    } inst_class_t;

    // encodings match what EX expects
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_mode_t;

    typedef enum logic [1:0] {OPA_ZERO, OPA_RS1, OPA_PC, OPA_IMM_U} opa_sel_t;

    typedef enum logic [2:0] {
        OPB_ZERO,
        OPB_RS2,
        OPB_RS2_SHAMT,   // low 6 bits of rs2
        OPB_SHAMT,       // shamt field of the word
        OPB_IMM_I,
        OPB_IMM_S,
        OPB_IMM_U,
        OPB_IMM_J
    } opb_sel_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // sub / sra

endpackage

// File: logic/id_stage.sv
// instruction decode stage top, stage register with stall hold feeding the decode blocks
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  decode_pkg::xlen_t      gpr [decode_pkg::NUM_REGS],
    input  decode_pkg::busy_t      gpr_busy,
    input  logic                   valid_if,
    output logic                   ready_if,
    input  decode_pkg::xlen_t      pc_if,
    input  decode_pkg::inst_t      inst_if,
    output decode_pkg::xlen_t      alu_a,
    output decode_pkg::xlen_t      alu_b,
    output decode_pkg::alu_mode_t  alu_mode,
    output decode_pkg::inst_class_t inst_class,
    output decode_pkg::xlen_t      src2,
    output decode_pkg::reg_idx_t   rd,
    output logic                   wen,
    output logic                   valid_ex,
    output decode_pkg::xlen_t      pc_ex,
    output decode_pkg::inst_t      inst_ex
);
    import decode_pkg::*;

    logic  valid_q;
    xlen_t pc_q;
    inst_t inst_q;
    inst_t inst_d;
    logic  stall;

    decode_ctrl_if    ctrl_bus ();
    operand_fields_if field_bus ();

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (ready_if) begin
            valid_q <= valid_if;  // loads bubbles too
        end
    end

    always_ff @(posedge clk) begin
        if (ready_if) begin
            pc_q   <= pc_if;
            inst_q <= inst_if;
        end
    end

    assign inst_d   = valid_q ? inst_q : '0;  // empty slot decodes as nothing
    assign ready_if = !stall;

    inst_classifier u_classifier (.inst(inst_d), .ctrl(ctrl_bus));

    operand_fetch u_fetch (.inst(inst_d), .gpr(gpr), .fields(field_bus));

    operand_select u_select (
        .pc       (pc_q),
        .gpr_busy (gpr_busy),
        .ctrl     (ctrl_bus),
        .fields   (field_bus),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .stall    (stall)
    );

    assign alu_mode   = ctrl_bus.alu_mode;
    assign inst_class = ctrl_bus.inst_class;
    assign wen        = ctrl_bus.wen;
    assign src2       = field_bus.src2;  // store data
    assign rd         = inst_d[11:7];

    // bubble toward EX while held
    assign valid_ex = stall ? 1'b0 : valid_q;
    assign pc_ex    = stall ? '0 : pc_q;
    assign inst_ex  = stall ? '0 : inst_q;

endmodule

// File: logic/inst_classifier.sv
// instruction classifier, maps opcode/funct3/funct7 to class, ALU mode and operand selects
`timescale 1ns/1ps

module inst_classifier (
    input  decode_pkg::inst_t inst,
    decode_ctrl_if.cls        ctrl
);
    import decode_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    inst_class_t cls;
    alu_mode_t   mode;
    opa_sel_t    opa;
    opb_sel_t    opb;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        cls  = CLS_NONE;
        mode = ALU_ADD;
        opa  = OPA_RS1;
        opb  = OPB_ZERO;
        case (opcode)
            OPC_OP: begin
                cls = CLS_ALU;
                opb = OPB_RS2;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: mode = ALU_ADD;
                    {FUNCT7_ALT, 3'b000}: mode = ALU_SUB;
                    {7'b0000000, 3'b001}: begin mode = ALU_SLL; opb = OPB_RS2_SHAMT; end
                    {7'b0000000, 3'b010}: mode = ALU_SLT;
                    {7'b0000000, 3'b011}: mode = ALU_SLTU;
                    {7'b0000000, 3'b100}: mode = ALU_XOR;
                    {7'b0000000, 3'b101}: begin mode = ALU_SRL; opb = OPB_RS2_SHAMT; end
                    {FUNCT7_ALT, 3'b101}: begin mode = ALU_SRA; opb = OPB_RS2_SHAMT; end
                    {7'b0000000, 3'b110}: mode = ALU_OR;
                    {7'b0000000, 3'b111}: mode = ALU_AND;
                    default:              cls = CLS_NONE;  // M ext lands here
                endcase
            end
            OPC_OP_IMM: begin
                cls = CLS_ALU_IMM;
                opb = OPB_IMM_I;
                case (funct3)
                    3'b000: mode = ALU_ADD;
                    3'b010: mode = ALU_SLT;
                    3'b011: mode = ALU_SLTU;
                    3'b100: mode = ALU_XOR;
                    3'b110: mode = ALU_OR;
                    3'b111: mode = ALU_AND;
                    3'b001: begin
                        mode = ALU_SLL;
                        opb  = OPB_SHAMT;
                        if (inst[31:26] != 6'b000000) cls = CLS_NONE;
                    end
                    default: begin  // srli / srai, 6-bit shamt leaves funct6
                        opb = OPB_SHAMT;
                        if (inst[31:26] == 6'b000000) mode = ALU_SRL;
                        else if (inst[31:26] == FUNCT7_ALT[6:1]) mode = ALU_SRA;
                        else cls = CLS_NONE;
                    end
                endcase
            end
            OPC_LUI:    begin cls = CLS_LUI; opa = OPA_IMM_U; end
            OPC_AUIPC:  begin cls = CLS_AUIPC; opa = OPA_PC; opb = OPB_IMM_U; end
            OPC_JAL:    begin cls = CLS_JAL; opa = OPA_PC; opb = OPB_IMM_J; end
            OPC_JALR:   begin cls = (funct3 == 3'b000) ? CLS_JALR : CLS_NONE; opb = OPB_IMM_I; end
            OPC_BRANCH: begin
                cls  = (funct3[2:1] == 2'b01) ? CLS_NONE : CLS_BRANCH;
                mode = ALU_SUB;  // compare by subtract
                opb  = OPB_RS2;
            end
            OPC_LOAD:   begin cls = (funct3 == 3'b111) ? CLS_NONE : CLS_LOAD; opb = OPB_IMM_I; end
            OPC_STORE:  begin cls = funct3[2] ? CLS_NONE : CLS_STORE; opb = OPB_IMM_S; end
            default:    cls = CLS_NONE;
        endcase
        if (cls == CLS_NONE) begin
            mode = ALU_ADD;
            opa  = OPA_ZERO;
            opb  = OPB_ZERO;
        end
    end

    assign ctrl.inst_class = cls;
    assign ctrl.alu_mode   = mode;
    assign ctrl.opa_sel    = opa;
    assign ctrl.opb_sel    = opb;
    assign ctrl.use_rs1    = !(cls inside {CLS_NONE, CLS_LUI, CLS_AUIPC, CLS_JAL});
    assign ctrl.use_rs2    = cls inside {CLS_ALU, CLS_BRANCH, CLS_STORE};
    assign ctrl.wen        = cls inside {CLS_ALU, CLS_ALU_IMM, CLS_LUI, CLS_AUIPC,
                                         CLS_JAL, CLS_JALR, CLS_LOAD};

endmodule

// File: logic/operand_fetch.sv
// operand fetcher, slices register indices, builds immediates and reads the gpr file
`timescale 1ns/1ps

module operand_fetch (
    input  decode_pkg::inst_t inst,
    input  decode_pkg::xlen_t gpr [decode_pkg::NUM_REGS],
    operand_fields_if.fetch   fields
);
    import decode_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     sign;

    assign rs1  = inst[19:15];
    assign rs2  = inst[24:20];
    assign sign = inst[31];

    assign fields.rs1   = rs1;
    assign fields.rs2   = rs2;
    assign fields.shamt = inst[25:20];  // rv64 shift amount

    // all immediates sign extend from bit 31
    assign fields.imm_i = {{(XLEN-12){sign}}, inst[31:20]};
    assign fields.imm_s = {{(XLEN-12){sign}}, inst[31:25], inst[11:7]};
    assign fields.imm_u = {{(XLEN-32){sign}}, inst[31:12], 12'b0};
    assign fields.imm_j = {{(XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                           inst[30:21], 1'b0};

    // x0 comes from the file as is
    assign fields.src1 = gpr[rs1];
    assign fields.src2 = gpr[rs2];

endmodule

// File: logic/operand_fields_if.sv
// operand field bus from the operand fetcher to the operand selector
`timescale 1ns/1ps

interface operand_fields_if;
    import decode_pkg::*;

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      src1;
    xlen_t      src2;
    logic [5:0] shamt;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    xlen_t      imm_j;

    modport fetch (
        output rs1, rs2, src1, src2, shamt,
        output imm_i, imm_s, imm_u, imm_j
    );

    modport sel (
        input rs1, rs2, src1, src2, shamt,
        input imm_i, imm_s, imm_u, imm_j
    );

endinterface

// File: logic/operand_select.sv
// operand selector, muxes the ALU operands and checks the scoreboard for hazards
`timescale 1ns/1ps

module operand_select (
    input  decode_pkg::xlen_t pc,
    input  decode_pkg::busy_t gpr_busy,
    decode_ctrl_if.sel        ctrl,
    operand_fields_if.sel     fields,
    output decode_pkg::xlen_t alu_a,
    output decode_pkg::xlen_t alu_b,
    output logic              stall
);
    import decode_pkg::*;

    logic rs1_hazard;
    logic rs2_hazard;

    always_comb begin
        case (ctrl.opa_sel)
            OPA_RS1:   alu_a = fields.src1;
            OPA_PC:    alu_a = pc;
            OPA_IMM_U: alu_a = fields.imm_u;  // lui result passes through add
            default:   alu_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.opb_sel)
            OPB_RS2:       alu_b = fields.src2;
            OPB_RS2_SHAMT: alu_b = {{(XLEN-6){1'b0}}, fields.src2[5:0]};
            OPB_SHAMT:     alu_b = {{(XLEN-6){1'b0}}, fields.shamt};
            OPB_IMM_I:     alu_b = fields.imm_i;
            OPB_IMM_S:     alu_b = fields.imm_s;
            OPB_IMM_U:     alu_b = fields.imm_u;
            OPB_IMM_J:     alu_b = fields.imm_j;
            default:       alu_b = '0;
        endcase
    end

    // only sources the instruction reads can hold it
    assign rs1_hazard = ctrl.use_rs1 && gpr_busy[fields.rs1];
    assign rs2_hazard = ctrl.use_rs2 && gpr_busy[fields.rs2];
    assign stall      = rs1_hazard || rs2_hazard;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --timescale 1ns/1ps --top-module id_stage_tb \
    -f id_stage.f -o id_stage_sim
out=$(./obj_dir/id_stage_sim)
echo "$out"
if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// File: tb/id_stage_checker.sv
// decode stage checker, compares DUT outputs with expected values when asked
`timescale 1ns/1ps

module id_stage_checker (
    input  logic                    clk,
    input  logic                    check_en,
    input  logic                    check_last,
    input  int                      test_id,
    input  decode_pkg::inst_class_t inst_class, exp_cls,
    input  decode_pkg::alu_mode_t   alu_mode, exp_mode,
    input  decode_pkg::xlen_t       alu_a, exp_a, alu_b, exp_b, src2, exp_src2,
    input  decode_pkg::xlen_t       pc_ex, exp_pc_ex,
    input  decode_pkg::inst_t       inst_ex, exp_inst_ex,
    input  decode_pkg::reg_idx_t    rd, exp_rd,
    input  logic                    wen, exp_wen, ready_if, exp_ready, valid_ex, exp_valid_ex,
    output int                      tests_run,
    output int                      tests_failed
);
    int runs = 0;
    int fails = 0;
    int errs = 0;   // mismatches in the current test

    task automatic cmp(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch test %0d %s: got %h, expected %h", test_id, name, got, exp);
            errs = errs + 1;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            cmp("inst_class", 64'(inst_class), 64'(exp_cls));
            cmp("alu_mode", 64'(alu_mode), 64'(exp_mode));
            cmp("alu_a", alu_a, exp_a);
            cmp("alu_b", alu_b, exp_b);
            cmp("src2", src2, exp_src2);
            cmp("rd", 64'(rd), 64'(exp_rd));
            cmp("wen", 64'(wen), 64'(exp_wen));
            cmp("ready_if", 64'(ready_if), 64'(exp_ready));
            cmp("valid_ex", 64'(valid_ex), 64'(exp_valid_ex));
            cmp("pc_ex", pc_ex, exp_pc_ex);
            cmp("inst_ex", 64'(inst_ex), 64'(exp_inst_ex));
            if (check_last) begin
                runs = runs + 1;
                if (errs != 0) fails = fails + 1;
                $display("test %0d %s", test_id, (errs == 0) ? "ok" : "FAILED");
                errs = 0;
            end
        end
    end

    assign tests_run    = runs;
    assign tests_failed = fails;

endmodule

// File: tb/id_stage_tb.sv
// decode stage testbench that applies a table of instructions and checks the decoded outputs
`timescale 1ns/1ps

module id_stage_tb;
    import decode_pkg::*;

    typedef struct packed {
        inst_t       inst;
        xlen_t       pc;
        logic        valid;
        busy_t       busy;
        logic        rel;     // clear busy after the hold
        inst_class_t cls;
        alu_mode_t   mode;
        xlen_t       a;
        xlen_t       b;
        logic        wen;
        logic        stall;
    } entry_t;

    logic        clk, rst, valid_if, ready_if, wen, valid_ex;
    xlen_t       gpr [NUM_REGS];
    busy_t       gpr_busy;
    xlen_t       pc_if, alu_a, alu_b, src2, pc_ex;
    inst_t       inst_if, inst_ex;
    alu_mode_t   alu_mode;
    inst_class_t inst_class;
    reg_idx_t    rd;

    inst_class_t exp_cls;
    alu_mode_t   exp_mode;
    xlen_t       exp_a, exp_b, exp_src2, exp_pc_ex;
    inst_t       exp_inst_ex;
    reg_idx_t    exp_rd;
    logic        exp_wen, exp_ready, exp_valid_ex, check_en, check_last;
    int          test_id, tests_run, tests_failed, limit;
    int          cycles = 0;
    integer      seed;
    entry_t      tab [$];
    xlen_t       next_pc = 64'h0000_0040_8000_0000;

    tb_clock clk_gen (.clk(clk));
    id_stage uut (.*);
    id_stage_checker chk (.*);

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic void add_entry(inst_t inst, logic valid, busy_t busy, inst_class_t cls,
                                      alu_mode_t mode, xlen_t a, xlen_t b, logic wen,
                                      logic stall);
        entry_t e;
        e.inst  = inst;
        e.pc    = next_pc;
        e.valid = valid;
        e.busy  = busy;
        e.rel   = stall;
        e.cls   = cls;
        e.mode  = mode;
        e.a     = a;
        e.b     = b;
        e.wen   = wen;
        e.stall = stall;
        tab.push_back(e);
        next_pc = next_pc + 64'd4;
    endfunction

    // x7 = x3 op x5 with shifts on the low 6 bits of x5
    function automatic void r_op(logic [6:0] f7, logic [2:0] f3, alu_mode_t mode, logic shift);
        add_entry({f7, 5'd5, 5'd3, f3, 5'd7, OPC_OP}, 1'b1, '0, CLS_ALU, mode, gpr[3],
                  shift ? {58'b0, gpr[5][5:0]} : gpr[5], 1'b1, 1'b0);
    endfunction

    function automatic void i_op(logic [11:0] imm, logic [2:0] f3, alu_mode_t mode, xlen_t b);
        add_entry({imm, 5'd3, f3, 5'd7, OPC_OP_IMM}, 1'b1, '0, CLS_ALU_IMM, mode, gpr[3], b,
                  1'b1, 1'b0);
    endfunction

    function automatic void build_table();
        r_op(7'h00, 3'b000, ALU_ADD, 1'b0);
        r_op(FUNCT7_ALT, 3'b000, ALU_SUB, 1'b0);
        r_op(7'h00, 3'b001, ALU_SLL, 1'b1);
        r_op(7'h00, 3'b010, ALU_SLT, 1'b0);
        r_op(7'h00, 3'b011, ALU_SLTU, 1'b0);
        r_op(7'h00, 3'b100, ALU_XOR, 1'b0);
        r_op(7'h00, 3'b101, ALU_SRL, 1'b1);
        r_op(FUNCT7_ALT, 3'b101, ALU_SRA, 1'b1);
        r_op(7'h00, 3'b110, ALU_OR, 1'b0);
        r_op(7'h00, 3'b111, ALU_AND, 1'b0);
        for (int k = 0; k < 8; k++) begin
            if (k == 2 || k == 3) continue;   // no branch on these funct3
            add_entry({7'h7f, 5'd9, 5'd2, 3'(k), 5'h1e, OPC_BRANCH}, 1'b1, '0, CLS_BRANCH,
                      ALU_SUB, gpr[2], gpr[9], 1'b0, 1'b0);
        end
        i_op(12'h800, 3'b000, ALU_ADD, 64'hffff_ffff_ffff_f800);
        i_op(12'h7ff, 3'b010, ALU_SLT, 64'h7ff);
        i_op(12'hfff, 3'b011, ALU_SLTU, 64'hffff_ffff_ffff_ffff);
        i_op(12'h123, 3'b100, ALU_XOR, 64'h123);
        i_op(12'habc, 3'b110, ALU_OR, 64'hffff_ffff_ffff_fabc);
        i_op(12'h0f0, 3'b111, ALU_AND, 64'h0f0);
        i_op({6'b000000, 6'd63}, 3'b001, ALU_SLL, 64'd63);
        i_op({6'b000000, 6'd33}, 3'b101, ALU_SRL, 64'd33);
        i_op({6'b010000, 6'd5}, 3'b101, ALU_SRA, 64'd5);
        for (int k = 0; k < 7; k++) begin
            add_entry({12'hff8, 5'd4, 3'(k), 5'd8, OPC_LOAD}, 1'b1, '0, CLS_LOAD, ALU_ADD,
                      gpr[4], 64'hffff_ffff_ffff_fff8, 1'b1, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            add_entry({7'h40, 5'd6, 5'd4, 3'(k), 5'h05, OPC_STORE}, 1'b1, '0, CLS_STORE,
                      ALU_ADD, gpr[4], 64'hffff_ffff_ffff_f805, 1'b0, 1'b0);
        end
        add_entry({12'h804, 5'd3, 3'b000, 5'd1, OPC_JALR}, 1'b1, '0, CLS_JALR, ALU_ADD,
                  gpr[3], 64'hffff_ffff_ffff_f804, 1'b1, 1'b0);
        add_entry({20'hfedcb, 5'd10, OPC_LUI}, 1'b1, '1, CLS_LUI, ALU_ADD,
                  64'hffff_ffff_fedc_b000, 64'd0, 1'b1, 1'b0);
        add_entry({20'h12345, 5'd11, OPC_AUIPC}, 1'b1, '0, CLS_AUIPC, ALU_ADD, next_pc,
                  64'h1234_5000, 1'b1, 1'b0);
        add_entry({20'h80000, 5'd1, OPC_JAL}, 1'b1, '0, CLS_JAL, ALU_ADD, next_pc,
                  64'hffff_ffff_fff0_0000, 1'b1, 1'b0);
        add_entry({20'h00402, 5'd1, OPC_JAL}, 1'b1, '0, CLS_JAL, ALU_ADD, next_pc,
                  64'h2004, 1'b1, 1'b0);
        // scoreboard hazards, then busy bits the instruction does not read
        add_entry({7'h00, 5'd5, 5'd3, 3'b000, 5'd7, OPC_OP}, 1'b1, 32'h20, CLS_ALU, ALU_ADD,
                  gpr[3], gpr[5], 1'b1, 1'b1);
        add_entry({FUNCT7_ALT, 5'd5, 5'd3, 3'b000, 5'd7, OPC_OP}, 1'b1, 32'h8, CLS_ALU,
                  ALU_SUB, gpr[3], gpr[5], 1'b1, 1'b1);
        add_entry({7'h40, 5'd6, 5'd4, 3'b011, 5'h05, OPC_STORE}, 1'b1, 32'h40, CLS_STORE,
                  ALU_ADD, gpr[4], 64'hffff_ffff_ffff_f805, 1'b0, 1'b1);
        add_entry({12'h005, 5'd3, 3'b000, 5'd7, OPC_OP_IMM}, 1'b1, 32'h20, CLS_ALU_IMM,
                  ALU_ADD, gpr[3], 64'd5, 1'b1, 1'b0);
        // mul, ecall and an empty slot decode as nothing
        add_entry({7'h01, 5'd5, 5'd3, 3'b000, 5'd7, OPC_OP}, 1'b1, '1, CLS_NONE, ALU_ADD,
                  64'd0, 64'd0, 1'b0, 1'b0);
        add_entry(32'h0000_0073, 1'b1, '1, CLS_NONE, ALU_ADD, 64'd0, 64'd0, 1'b0, 1'b0);
        add_entry({7'h00, 5'd5, 5'd3, 3'b000, 5'd7, OPC_OP}, 1'b0, '1, CLS_NONE, ALU_ADD,
                  64'd0, 64'd0, 1'b0, 1'b0);
    endfunction

    task automatic set_expect(input entry_t e, input logic stalled);
        exp_cls      = e.cls;
        exp_mode     = e.mode;
        exp_a        = e.a;
        exp_b        = e.b;
        exp_wen      = e.wen;
        exp_rd       = e.valid ? e.inst[11:7] : 5'd0;
        exp_src2     = gpr[e.valid ? e.inst[24:20] : 5'd0];
        exp_ready    = !stalled;
        exp_valid_ex = stalled ? 1'b0 : e.valid;
        exp_pc_ex    = stalled ? '0 : e.pc;
        exp_inst_ex  = stalled ? '0 : e.inst;
    endtask

    task automatic check_now(input logic last);
        check_last = last;
        check_en   = 1'b1;
        @(negedge clk);
        #1;
        check_en = 1'b0;
    endtask

    initial begin
        entry_t e;
        entry_t idle;
        rst        = 1'b1;
        valid_if   = 1'b0;
        pc_if      = '0;
        inst_if    = '0;
        gpr_busy   = '0;
        check_en   = 1'b0;
        check_last = 1'b0;
        test_id    = 0;
        seed       = 32'hd99e_fed9;
        for (int r = 0; r < NUM_REGS; r++) begin
            gpr[r] = {$random(seed), $random(seed)};
        end
        build_table();
        limit = tab.size() * 4 + 20;
        repeat (2) @(posedge clk);
        #1;
        rst  = 1'b0;
        idle = '0;   // empty slot after reset
        set_expect(idle, 1'b0);
        check_now(1'b1);
        for (int i = 0; i < tab.size(); i++) begin
            e       = tab[i];
            test_id = i + 1;
            @(posedge clk);
            #1;
            valid_if = e.valid;
            pc_if    = e.pc;
            inst_if  = e.inst;
            gpr_busy = '0;
            @(posedge clk);   // accepting edge
            #1;
            valid_if = 1'b0;
            gpr_busy = e.busy;
            set_expect(e, e.stall);
            check_now(!e.stall);
            if (e.stall) begin
                @(posedge clk);
                #1;
                check_now(1'b0);   // still held
            end
            if (e.rel) begin
                @(posedge clk);
                #1;
                gpr_busy = '0;
                wait (ready_if);
                set_expect(e, 1'b0);
                check_now(1'b1);
            end
        end
        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0 && tests_run == tab.size() + 1) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
// testbench clock source, 40 ns period
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    initial clk = 1'b0;

    always #20 clk = ~clk;

endmodule
